//--- src/video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// Horizontal raster timing in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// Vertical raster timing in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

// Both syncs are active low
`define SYNC_ACTIVE_LEVEL 1'b0

// Frame buffer geometry and the upscale factor as a shift
`define FB_WIDTH 160
`define FB_HEIGHT 120
`define FB_DEPTH (`FB_WIDTH * `FB_HEIGHT)
`define SCALE_SHIFT 2

// APB register map, byte addresses
`define REG_CTRL 8'h00
`define REG_PIX_ADDR 8'h04
`define REG_PIX_DATA 8'h08
`define REG_FRAME_COUNT 8'h0C

`endif

//--- src/video_pkg.sv
package video_pkg;

    // Raster counters, wide enough for 800 and 525
    typedef logic [9:0] h_count_t;
    typedef logic [9:0] v_count_t;

    // One VGA colour channel
    typedef logic [3:0] chan_t;

    // Registered output of the timing generator
    typedef struct packed {
        logic     hsync;
        logic     vsync;
        logic     active;
        // One cycle pulse on the first line of vertical blanking
        logic     frame_start;
        h_count_t x;
        v_count_t y;
    } timing_t;

endpackage

//--- src/buffer_pkg.sv
package buffer_pkg;

    // Pixel index into one 160x120 buffer
    typedef logic [14:0] fb_addr_t;

    // 4:4:4 colour, red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] pixel_t;

    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        pixel_t   data;
    } fb_write_t;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

endpackage

//--- src/video_timing.sv
`timescale 1ns/1ps

`include "video_macros.svh"

module video_timing (
    input  logic               clk_display,
    input  logic               rstn_display,
    output video_pkg::timing_t timing
);
    import video_pkg::*;

    localparam int H_TOTAL      = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL      = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + `H_SYNC;
    localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + `V_SYNC;

    h_count_t h_count;
    v_count_t v_count;

    logic h_in_sync;
    logic v_in_sync;
    logic in_active;
    logic at_frame_start;

    //////////////////////////////////////////////////////////////////////
    // Raster counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == h_count_t'(H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == v_count_t'(V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // Decode from the current count, registered below
    always_comb begin
        h_in_sync = (h_count >= h_count_t'(H_SYNC_START)) && (h_count < h_count_t'(H_SYNC_END));
        v_in_sync = (v_count >= v_count_t'(V_SYNC_START)) && (v_count < v_count_t'(V_SYNC_END));
        in_active = (h_count < h_count_t'(`H_ACTIVE)) && (v_count < v_count_t'(`V_ACTIVE));
        // First pixel of the first blank line
        at_frame_start = (h_count == '0) && (v_count == v_count_t'(`V_ACTIVE));
    end

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            timing.hsync       <= ~`SYNC_ACTIVE_LEVEL;
            timing.vsync       <= ~`SYNC_ACTIVE_LEVEL;
            timing.active      <= 1'b0;
            timing.frame_start <= 1'b0;
            timing.x           <= '0;
            timing.y           <= '0;
        end else begin
            timing.hsync       <= h_in_sync ? `SYNC_ACTIVE_LEVEL : ~`SYNC_ACTIVE_LEVEL;
            timing.vsync       <= v_in_sync ? `SYNC_ACTIVE_LEVEL : ~`SYNC_ACTIVE_LEVEL;
            timing.active      <= in_active;
            timing.frame_start <= at_frame_start;
            timing.x           <= h_count;
            timing.y           <= v_count;
        end
    end

    // Horizontal sync pulse lies entirely inside blanking
    hsync_outside_active: assert property (
        @(posedge clk_display) disable iff (!rstn_display)
        timing.active |-> (timing.hsync != `SYNC_ACTIVE_LEVEL)
    ) else $error("hsync asserted during active video");

endmodule

//--- src/frame_buffer.sv
`timescale 1ns/1ps

`include "video_macros.svh"

module frame_buffer (
    input  logic                  clk_display,
    input  buffer_pkg::fb_write_t write,
    input  buffer_pkg::fb_addr_t  read_addr,
    output buffer_pkg::pixel_t    read_data
);
    import buffer_pkg::*;

    // Image storage, no reset so it maps to block RAM
    pixel_t mem [`FB_DEPTH];

    always_ff @(posedge clk_display) begin
        if (write.en) begin
            mem[write.addr] <= write.data;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk_display) begin
        read_data <= mem[read_addr];
    end

    // Host pointer and routing must keep writes inside the image
    write_in_range: assert property (
        @(posedge clk_display)
        write.en |-> (write.addr < fb_addr_t'(`FB_DEPTH))
    ) else $error("frame buffer write address %0d out of range", write.addr);

endmodule

//--- src/buffer_regs.sv
`timescale 1ns/1ps

`include "video_macros.svh"

module buffer_regs (
    input  logic                  clk_display,
    input  logic                  rstn_display,
    input  buffer_pkg::apb_req_t  apb_req,
    output buffer_pkg::apb_rsp_t  apb_rsp,
    input  logic                  frame_start,
    input  logic                  front_sel,
    input  logic                  swap_done,
    output logic                  swap_pending,
    output buffer_pkg::fb_write_t host_write
);
    import buffer_pkg::*;

    fb_addr_t    pix_ptr;
    logic [15:0] frame_count;

    logic access;
    logic wr_access;
    logic rd_access;
    logic sel_ctrl;
    logic sel_pix_addr;
    logic sel_pix_data;
    logic sel_frame_count;
    logic mapped;
    logic pix_blocked;
    logic pix_write;

    //////////////////////////////////////////////////////////////////////
    // APB decode, access phase completes in one cycle
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        access          = apb_req.psel && apb_req.penable;
        wr_access       = access && apb_req.pwrite;
        rd_access       = access && !apb_req.pwrite;
        sel_ctrl        = (apb_req.paddr == `REG_CTRL);
        sel_pix_addr    = (apb_req.paddr == `REG_PIX_ADDR);
        sel_pix_data    = (apb_req.paddr == `REG_PIX_DATA);
        sel_frame_count = (apb_req.paddr == `REG_FRAME_COUNT);
        mapped          = sel_ctrl || sel_pix_addr || sel_pix_data || sel_frame_count;
        // Back buffer is frozen while a swap waits for blanking
        pix_blocked     = wr_access && sel_pix_data && swap_pending;
        pix_write       = wr_access && sel_pix_data && !swap_pending;
    end

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = (access && !mapped) || pix_blocked;
        apb_rsp.prdata  = '0;
        if (rd_access) begin
            case (apb_req.paddr)
                `REG_CTRL:        apb_rsp.prdata = {30'b0, front_sel, swap_pending};
                `REG_PIX_ADDR:    apb_rsp.prdata = {17'b0, pix_ptr};
                `REG_FRAME_COUNT: apb_rsp.prdata = {16'b0, frame_count};
                default:          apb_rsp.prdata = '0;
            endcase
        end
    end

    // Pixel write goes out in the access cycle itself
    always_comb begin
        host_write.en   = pix_write;
        host_write.addr = pix_ptr;
        host_write.data = pixel_t'(apb_req.pwdata[11:0]);
    end

    //////////////////////////////////////////////////////////////////////
    // Register state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            pix_ptr <= '0;
        end else if (wr_access && sel_pix_addr) begin
            pix_ptr <= fb_addr_t'(apb_req.pwdata[14:0]);
        end else if (pix_write) begin
            if (pix_ptr >= fb_addr_t'(`FB_DEPTH - 1)) begin
                pix_ptr <= '0;
            end else begin
                pix_ptr <= pix_ptr + 1'b1;
            end
        end
    end

    // A new request in the swap cycle keeps the flag set
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            swap_pending <= 1'b0;
        end else if (wr_access && sel_ctrl && apb_req.pwdata[0]) begin
            swap_pending <= 1'b1;
        end else if (swap_done) begin
            swap_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            frame_count <= '0;
        end else if (frame_start) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    // Back buffer stays frozen until the pending swap has flipped
    no_write_while_pending: assert property (
        @(posedge clk_display) disable iff (!rstn_display)
        (swap_pending && !swap_done) |=> !host_write.en
    ) else $error("pixel write issued while a swap is pending");

endmodule

//--- src/buffer_swap.sv
`timescale 1ns/1ps

module buffer_swap (
    input  logic                  clk_display,
    input  logic                  rstn_display,
    input  logic                  frame_start,
    input  logic                  swap_pending,
    input  buffer_pkg::fb_write_t host_write,
    input  buffer_pkg::fb_addr_t  read_addr,
    output buffer_pkg::pixel_t    read_data,
    output logic                  front_sel,
    output logic                  swap_done
);
    import buffer_pkg::*;

    // Select as seen by the RAM read issued one cycle earlier
    logic front_sel_q;

    fb_write_t write_a;
    fb_write_t write_b;
    fb_addr_t  read_addr_a;
    fb_addr_t  read_addr_b;
    pixel_t    read_data_a;
    pixel_t    read_data_b;

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            front_sel   <= 1'b0;
            front_sel_q <= 1'b0;
            swap_done   <= 1'b0;
        end else begin
            front_sel_q <= front_sel;
            swap_done   <= frame_start && swap_pending;
            if (frame_start && swap_pending) begin
                front_sel <= ~front_sel;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Routing, front_sel 0 shows A and draws into B
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        write_a     = host_write;
        write_b     = host_write;
        write_a.en  = host_write.en && front_sel;
        write_b.en  = host_write.en && !front_sel;
        read_addr_a = front_sel ? '0 : read_addr;
        read_addr_b = front_sel ? read_addr : '0;
        read_data   = front_sel_q ? read_data_b : read_data_a;
    end

    frame_buffer buffer_a (
        .clk_display (clk_display),
        .write       (write_a),
        .read_addr   (read_addr_a),
        .read_data   (read_data_a)
    );

    frame_buffer buffer_b (
        .clk_display (clk_display),
        .write       (write_b),
        .read_addr   (read_addr_b),
        .read_data   (read_data_b)
    );

    // Front buffer only flips right after the start of vertical blanking
    swap_at_vblank: assert property (
        @(posedge clk_display) disable iff (!rstn_display)
        $changed(front_sel) |-> $past(frame_start)
    ) else $error("front_sel changed outside vertical blank start");

endmodule

//--- src/pixel_scanout.sv
`timescale 1ns/1ps

`include "video_macros.svh"

module pixel_scanout (
    input  logic                 clk_display,
    input  logic                 rstn_display,
    input  video_pkg::timing_t   timing,
    output buffer_pkg::fb_addr_t read_addr,
    input  buffer_pkg::pixel_t   read_data,
    output logic                 vga_hsync,
    output logic                 vga_vsync,
    output logic                 vga_de,
    output video_pkg::chan_t     vga_red,
    output video_pkg::chan_t     vga_green,
    output video_pkg::chan_t     vga_blue
);
    import video_pkg::*;
    import buffer_pkg::*;

    fb_addr_t src_row;
    fb_addr_t src_col;

    // Flags delayed to line up with the RAM data
    logic hsync_d;
    logic vsync_d;
    logic de_d;

    // Each source pixel covers a 4x4 block of screen pixels
    always_comb begin
        src_row = fb_addr_t'(timing.y >> `SCALE_SHIFT);
        src_col = fb_addr_t'(timing.x >> `SCALE_SHIFT);
        // Park at 0 in blanking, the raster runs past the image
        if (timing.active) begin
            read_addr = src_row * fb_addr_t'(`FB_WIDTH) + src_col;
        end else begin
            read_addr = '0;
        end
    end

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            hsync_d <= ~`SYNC_ACTIVE_LEVEL;
            vsync_d <= ~`SYNC_ACTIVE_LEVEL;
            de_d    <= 1'b0;
        end else begin
            hsync_d <= timing.hsync;
            vsync_d <= timing.vsync;
            de_d    <= timing.active;
        end
    end

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            vga_hsync <= ~`SYNC_ACTIVE_LEVEL;
            vga_vsync <= ~`SYNC_ACTIVE_LEVEL;
            vga_de    <= 1'b0;
            vga_red   <= '0;
            vga_green <= '0;
            vga_blue  <= '0;
        end else begin
            vga_hsync <= hsync_d;
            vga_vsync <= vsync_d;
            vga_de    <= de_d;
            vga_red   <= de_d ? chan_t'(read_data[11:8]) : '0;
            vga_green <= de_d ? chan_t'(read_data[7:4]) : '0;
            vga_blue  <= de_d ? chan_t'(read_data[3:0]) : '0;
        end
    end

endmodule

//--- src/display_top.sv
`timescale 1ns/1ps

module display_top (
    input  logic                 clk_display,
    input  logic                 rstn_display,
    input  buffer_pkg::apb_req_t apb_req,
    output buffer_pkg::apb_rsp_t apb_rsp,
    output logic                 vga_hsync,
    output logic                 vga_vsync,
    output logic                 vga_de,
    output video_pkg::chan_t     vga_red,
    output video_pkg::chan_t     vga_green,
    output video_pkg::chan_t     vga_blue
);
    import video_pkg::*;
    import buffer_pkg::*;

    timing_t   timing;
    fb_write_t host_write;
    fb_addr_t  read_addr;
    pixel_t    read_data;
    logic      swap_pending;
    logic      swap_done;
    logic      front_sel;

    //////////////////////////////////////////////////////////////////////
    // Raster and host side
    //////////////////////////////////////////////////////////////////////

    video_timing i_video_timing (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .timing       (timing)
    );

    buffer_regs i_buffer_regs (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .frame_start  (timing.frame_start),
        .front_sel    (front_sel),
        .swap_done    (swap_done),
        .swap_pending (swap_pending),
        .host_write   (host_write)
    );

    //////////////////////////////////////////////////////////////////////
    // Double buffer and scanout
    //////////////////////////////////////////////////////////////////////

    buffer_swap i_buffer_swap (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .frame_start  (timing.frame_start),
        .swap_pending (swap_pending),
        .host_write   (host_write),
        .read_addr    (read_addr),
        .read_data    (read_data),
        .front_sel    (front_sel),
        .swap_done    (swap_done)
    );

    pixel_scanout i_pixel_scanout (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .timing       (timing),
        .read_addr    (read_addr),
        .read_data    (read_data),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_de       (vga_de),
        .vga_red      (vga_red),
        .vga_green    (vga_green),
        .vga_blue     (vga_blue)
    );

endmodule

//--- verif/display_tb.sv
`timescale 1ns/1ps

`include "video_macros.svh"

module display_tb;
    import video_pkg::*;
    import buffer_pkg::*;

    localparam int H_TOTAL        = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL        = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT_CYCLES = 8 * FRAME_CYCLES + 80000;

    logic     clk_display;
    logic     rstn_display;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     vga_hsync;
    logic     vga_vsync;
    logic     vga_de;
    chan_t    vga_red;
    chan_t    vga_green;
    chan_t    vga_blue;

    // Reference images for both buffers and the expected front select
    pixel_t model_mem [2][`FB_DEPTH];
    logic   model_front;

    // Raster monitor state, holds the last consumed output cycle
    logic mon_hsync;
    logic mon_vsync;
    logic mon_de;
    int   hs_low_len;
    int   hs_period;
    logic hs_seen;
    int   vs_low_len;
    logic vs_seen;
    int   vs_fall_count;
    int   pix_x;
    int   pix_y;
    int   rst_cycles;
    int   cycle_count = 0;

    // Expectations for the APB checks
    logic      exp_slverr;
    logic      rd_check;
    apb_data_t rd_exp;
    apb_data_t rd_mask;
    logic      pix_check_en;

    apb_data_t  count_before;
    int         falls_before;
    fb_addr_t   hold_ptr;

    logic        hs_fall;
    logic        hs_rise;
    logic        vs_fall;
    logic        vs_rise;
    logic        de_fall;
    logic        apb_access;
    pixel_t      colour;
    pixel_t      exp_pixel;
    int          pix_index;
    logic [14:0] reset_view;

    display_top i_display_top (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_de       (vga_de),
        .vga_red      (vga_red),
        .vga_green    (vga_green),
        .vga_blue     (vga_blue)
    );

    initial begin
        clk_display = 1'b0;
        forever #2 clk_display = ~clk_display;
    end

    assign hs_fall    = mon_hsync && !vga_hsync;
    assign hs_rise    = !mon_hsync && vga_hsync;
    assign vs_fall    = mon_vsync && !vga_vsync;
    assign vs_rise    = !mon_vsync && vga_vsync;
    assign de_fall    = mon_de && !vga_de;
    assign apb_access = apb_req.psel && apb_req.penable;
    assign colour     = {vga_red, vga_green, vga_blue};
    assign reset_view = {vga_hsync, vga_vsync, vga_de, colour};
    // Each image pixel is shown as a 4x4 block
    assign pix_index  = (pix_y / 4) * `FB_WIDTH + pix_x / 4;
    assign exp_pixel  = model_mem[model_front][pix_index];

    //////////////////////////////////////////////////////////////////////
    // Raster monitor, consumes the outputs of the cycle just ended
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_display) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "simulation timeout");
        end
    end

    always @(posedge clk_display) begin
        if (!rstn_display) begin
            mon_hsync     <= 1'b1;
            mon_vsync     <= 1'b1;
            mon_de        <= 1'b0;
            hs_low_len    <= 0;
            hs_period     <= 0;
            hs_seen       <= 1'b0;
            vs_low_len    <= 0;
            vs_seen       <= 1'b0;
            vs_fall_count <= 0;
            pix_x         <= 0;
            pix_y         <= 0;
            rst_cycles    <= 0;
        end else begin
            mon_hsync  <= vga_hsync;
            mon_vsync  <= vga_vsync;
            mon_de     <= vga_de;
            hs_low_len <= vga_hsync ? 0 : hs_low_len + 1;
            vs_low_len <= vga_vsync ? 0 : vs_low_len + 1;
            pix_x      <= vga_de ? pix_x + 1 : 0;
            if (rst_cycles < 3) begin
                rst_cycles <= rst_cycles + 1;
            end
            if (hs_fall) begin
                hs_period <= 1;
                hs_seen   <= 1'b1;
            end else begin
                hs_period <= hs_period + 1;
            end
            // Lines are counted from each vsync falling edge
            if (vs_fall) begin
                vs_seen       <= 1'b1;
                vs_fall_count <= vs_fall_count + 1;
                pix_y         <= 0;
            end else if (de_fall) begin
                pix_y <= pix_y + 1;
            end
        end
    end

    task automatic value_error(input string name, input int got, input int expected);
        $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
        $display("*** FAILED ***");
        $fatal(1, "output mismatch");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks, sampled mid-cycle where all outputs are settled
    //////////////////////////////////////////////////////////////////////

    reset_outputs_ok: assert property (@(negedge clk_display)
        (!rstn_display || rst_cycles < 3) |-> reset_view == 15'h6000
    ) else value_error("{hsync,vsync,de,colour} in reset", reset_view, 15'h6000);

    blank_colour_ok: assert property (@(negedge clk_display)
        !vga_de |-> colour == '0
    ) else value_error("colour in blanking", colour, 0);

    hsync_width_ok: assert property (@(negedge clk_display) disable iff (!rstn_display)
        hs_rise |-> hs_low_len == `H_SYNC
    ) else value_error("hsync low cycles", hs_low_len, `H_SYNC);

    hsync_period_ok: assert property (@(negedge clk_display) disable iff (!rstn_display)
        (hs_fall && hs_seen) |-> hs_period == H_TOTAL
    ) else value_error("hsync period", hs_period, H_TOTAL);

    line_length_ok: assert property (@(negedge clk_display) disable iff (!rstn_display)
        de_fall |-> pix_x == `H_ACTIVE
    ) else value_error("de cycles per line", pix_x, `H_ACTIVE);

    frame_lines_ok: assert property (@(negedge clk_display) disable iff (!rstn_display)
        (vs_fall && vs_seen) |-> pix_y == `V_ACTIVE
    ) else value_error("de lines per frame", pix_y, `V_ACTIVE);

    vsync_width_ok: assert property (@(negedge clk_display) disable iff (!rstn_display)
        vs_rise |-> vs_low_len == `V_SYNC * H_TOTAL
    ) else value_error("vsync low cycles", vs_low_len, `V_SYNC * H_TOTAL);

    pixel_ok: assert property (@(negedge clk_display) disable iff (!rstn_display)
        (pix_check_en && vga_de) |-> colour == exp_pixel
    ) else value_error($sformatf("colour at x=%0d y=%0d", pix_x, pix_y), colour, exp_pixel);

    pready_ok: assert property (@(negedge clk_display) disable iff (!rstn_display)
        apb_access |-> apb_rsp.pready
    ) else value_error("apb pready", apb_rsp.pready, 1);

    slverr_ok: assert property (@(negedge clk_display) disable iff (!rstn_display)
        apb_access |-> apb_rsp.pslverr == exp_slverr
    ) else value_error("apb pslverr", apb_rsp.pslverr, exp_slverr);

    prdata_ok: assert property (@(negedge clk_display) disable iff (!rstn_display)
        (apb_access && rd_check) |-> (apb_rsp.prdata & rd_mask) == rd_exp
    ) else value_error("apb prdata", apb_rsp.prdata & rd_mask, rd_exp);

    //////////////////////////////////////////////////////////////////////
    // APB host, entered and left just after a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input apb_data_t wdata, input logic slverr,
                                output apb_data_t rdata);
        apb_req_t req;
        req        = '0;
        req.psel   = 1'b1;
        req.pwrite = write;
        req.paddr  = addr;
        req.pwdata = wdata;
        exp_slverr = slverr;
        apb_req   <= req;
        @(posedge clk_display);
        req.penable = 1'b1;
        apb_req    <= req;
        @(negedge clk_display);
        rdata = apb_rsp.prdata;
        @(posedge clk_display);
        apb_req <= '0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, input logic slverr);
        apb_data_t unused;
        apb_transfer(1'b1, addr, wdata, slverr, unused);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
        apb_transfer(1'b0, addr, '0, 1'b0, rdata);
    endtask

    task automatic read_expect(input apb_addr_t addr, input apb_data_t exp, input apb_data_t mask);
        apb_data_t unused;
        rd_exp   = exp & mask;
        rd_mask  = mask;
        rd_check = 1'b1;
        apb_transfer(1'b0, addr, '0, 1'b0, unused);
        rd_check = 1'b0;
    endtask

    // Random image into the back buffer, pointer wraps to 0 at the end
    task automatic fill_back_buffer();
        pixel_t pix;
        int     i;
        apb_write(`REG_PIX_ADDR, '0, 1'b0);
        for (i = 0; i < `FB_DEPTH; i++) begin
            pix = pixel_t'($urandom);
            model_mem[~model_front][i] = pix;
            apb_write(`REG_PIX_DATA, {20'b0, pix}, 1'b0);
        end
        read_expect(`REG_PIX_ADDR, '0, 32'hFFFF_FFFF);
    endtask

    task automatic wait_vsync_fall();
        int start;
        start = vs_fall_count;
        do begin
            @(posedge clk_display);
        end while (vs_fall_count == start);
    endtask

    // Poll until the swap lands, then confirm the new front select
    task automatic wait_swap();
        apb_data_t rdata;
        do begin
            repeat (100) @(posedge clk_display);
            apb_read(`REG_CTRL, rdata);
        end while (rdata[0]);
        model_front = ~model_front;
        read_expect(`REG_CTRL, {30'b0, model_front, 1'b0}, 32'h3);
    endtask

    task automatic check_next_frame();
        wait_vsync_fall();
        pix_check_en = 1'b1;
        wait_vsync_fall();
        pix_check_en = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(62967));
        rstn_display = 1'b0;
        apb_req      = '0;
        model_front  = 1'b0;
        exp_slverr   = 1'b0;
        rd_check     = 1'b0;
        rd_exp       = '0;
        rd_mask      = '0;
        pix_check_en = 1'b0;
        repeat (8) @(posedge clk_display);
        rstn_display <= 1'b1;
        repeat (2) @(posedge clk_display);

        read_expect(`REG_CTRL, '0, 32'hFFFF_FFFF);

        // First image and swap
        fill_back_buffer();
        apb_write(`REG_CTRL, 32'h1, 1'b0);
        wait_swap();
        check_next_frame();

        // Frame count baseline, taken just after a vsync edge
        apb_read(`REG_FRAME_COUNT, count_before);
        falls_before = vs_fall_count;

        apb_write(8'h10, 32'h1, 1'b1);

        // Second image, then a blocked pixel write while the swap waits
        fill_back_buffer();
        hold_ptr = fb_addr_t'($urandom % `FB_DEPTH);
        apb_write(`REG_PIX_ADDR, {17'b0, hold_ptr}, 1'b0);
        apb_write(`REG_CTRL, 32'h1, 1'b0);
        apb_write(`REG_PIX_DATA, 32'hABC, 1'b1);
        read_expect(`REG_PIX_ADDR, {17'b0, hold_ptr}, 32'hFFFF_FFFF);
        wait_swap();
        check_next_frame();

        read_expect(`REG_FRAME_COUNT, count_before + apb_data_t'(vs_fall_count - falls_before),
                    32'h0000_FFFF);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- all.f
+incdir+src
src/video_pkg.sv
src/buffer_pkg.sv
src/video_timing.sv
src/frame_buffer.sv
src/buffer_regs.sv
src/buffer_swap.sv
src/pixel_scanout.sv
src/display_top.sv
verif/display_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = display_tb
FLIST = all.f
LOG   = sim.log

.PHONY: sim clean

# The log search decides pass or fail, so a failing run returns a non-zero status
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q -F "*** PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
